//--- dec_if.sv
`default_nettype none

// Decoded instruction fields, decode to execute
interface dec_if;

    rv_pkg::reg_addr_t rs1_addr;
    rv_pkg::reg_addr_t rs2_addr;
    rv_pkg::reg_addr_t rd;
    rv_pkg::word_t     imm;
    rv_pkg::alu_op_t   alu_op;
    logic              use_imm;   // Operand B from imm
    logic              reg_we;    // Supported opcode and rd != x0

    modport decoder (
        output rs1_addr, rs2_addr, rd, imm, alu_op, use_imm, reg_we
    );

    modport execute (
        input rs1_addr, rs2_addr, rd, imm, alu_op, use_imm, reg_we
    );

endinterface

`default_nettype wire

//--- execute_stage.sv
`default_nettype none

module execute_stage (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              inst_valid,
    output logic                   inst_ready,
    dec_if.execute                 dec,
    input  wire rv_pkg::word_t     rs1_data,
    input  wire rv_pkg::word_t     rs2_data,
    output logic                   wb_we,
    output rv_pkg::reg_addr_t      wb_rd,
    output rv_pkg::word_t          wb_data,
    output logic                   retire_valid,
    input  wire logic              retire_ready,
    output rv_pkg::reg_addr_t      retire_rd,
    output logic                   retire_we,
    output rv_pkg::word_t          retire_data
);

    // S1 operand register
    logic              s1_valid;
    rv_pkg::word_t     s1_a;
    rv_pkg::word_t     s1_b;
    rv_pkg::word_t     s1_imm;
    rv_pkg::alu_op_t   s1_alu_op;
    logic              s1_use_imm;
    logic              s1_we;
    rv_pkg::reg_addr_t s1_rd;

    rv_pkg::word_t     fwd_a;
    rv_pkg::word_t     fwd_b;
    rv_pkg::word_t     alu_b;
    rv_pkg::word_t     alu_result;
    logic              r_free;
    logic              r_load;
    logic              accept;

    assign r_free     = !retire_valid || retire_ready;  // R empty or draining
    assign r_load     = s1_valid && r_free;
    assign inst_ready = !s1_valid || r_free;
    assign accept     = inst_valid && inst_ready;

    // S1 result reaches the register file on the same edge that captures the new operands
    assign fwd_a = (s1_valid && s1_we && (s1_rd == dec.rs1_addr)) ? alu_result : rs1_data;
    assign fwd_b = (s1_valid && s1_we && (s1_rd == dec.rs2_addr)) ? alu_result : rs2_data;

    assign alu_b = s1_use_imm ? s1_imm : s1_b;

    always_comb begin
        case (s1_alu_op)
            rv_pkg::ALU_ADD:    alu_result = s1_a + alu_b;
            rv_pkg::ALU_SUB:    alu_result = s1_a - alu_b;
            rv_pkg::ALU_AND:    alu_result = s1_a & alu_b;
            rv_pkg::ALU_OR:     alu_result = s1_a | alu_b;
            rv_pkg::ALU_XOR:    alu_result = s1_a ^ alu_b;
            rv_pkg::ALU_SLT:    alu_result = {31'b0, $signed(s1_a) < $signed(alu_b)};
            rv_pkg::ALU_SLL:    alu_result = s1_a << alu_b[4:0];
            rv_pkg::ALU_SRL:    alu_result = s1_a >> alu_b[4:0];
            rv_pkg::ALU_PASS_B: alu_result = alu_b;
            default:            alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (accept) begin
            s1_valid <= 1'b1;   // Also covers S1 moving to R on this edge
        end else if (r_load) begin
            s1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_a       <= fwd_a;
            s1_b       <= fwd_b;
            s1_imm     <= dec.imm;
            s1_alu_op  <= dec.alu_op;
            s1_use_imm <= dec.use_imm;
            s1_we      <= dec.reg_we;
            s1_rd      <= dec.rd;
        end
    end

    // Retire register R
    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else if (r_load) begin
            retire_valid <= 1'b1;
        end else if (retire_ready) begin
            retire_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (r_load) begin
            retire_rd   <= s1_rd;
            retire_we   <= s1_we;
            retire_data <= alu_result;
        end
    end

    // Register write lands with the R load
    assign wb_we   = r_load && s1_we;
    assign wb_rd   = s1_rd;
    assign wb_data = alu_result;

endmodule

`default_nettype wire

//--- files.f
rv_pkg.sv
dec_if.sv
reg_file.sv
inst_decode.sv
execute_stage.sv
rv_core.sv
rv_core_assertions.sv
tb_rv_core.sv

//--- inst_decode.sv
`default_nettype none

module inst_decode (
    input  wire rv_pkg::word_t inst,
    dec_if.decoder             dec
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic              alt;        // funct7 bit 5, selects SUB or SRA
    rv_pkg::reg_addr_t rd;
    rv_pkg::word_t     imm_i;
    rv_pkg::word_t     imm_u;
    logic              is_op;
    logic              is_op_imm;
    logic              is_lui;
    logic              funct_ok;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign alt    = inst[30];
    assign rd     = inst[11:7];

    assign is_op     = (opcode == rv_pkg::OPC_OP);
    assign is_op_imm = (opcode == rv_pkg::OPC_OP_IMM);
    assign is_lui    = (opcode == rv_pkg::OPC_LUI);

    // Register fields go out unchanged
    assign dec.rs1_addr = inst[19:15];
    assign dec.rs2_addr = inst[24:20];
    assign dec.rd       = rd;

    // Immediate formats
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};

    assign dec.imm     = is_lui ? imm_u : imm_i;
    assign dec.use_imm = is_op_imm || is_lui;

    always_comb begin
        dec.alu_op = rv_pkg::ALU_ADD;
        funct_ok   = 1'b1;
        if (is_lui) begin
            dec.alu_op = rv_pkg::ALU_PASS_B;
        end else begin
            case (funct3)
                3'b000: begin
                    // ADDI has no SUB form
                    dec.alu_op = (is_op && alt) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                end
                3'b001: dec.alu_op = rv_pkg::ALU_SLL;
                3'b010: dec.alu_op = rv_pkg::ALU_SLT;
                3'b100: dec.alu_op = rv_pkg::ALU_XOR;
                3'b101: begin
                    dec.alu_op = rv_pkg::ALU_SRL;
                    funct_ok   = !alt;      // No arithmetic shift
                end
                3'b110: dec.alu_op = rv_pkg::ALU_OR;
                3'b111: dec.alu_op = rv_pkg::ALU_AND;
                default: funct_ok = 1'b0;   // SLTU and SLTIU
            endcase
        end
    end

    // Writes to x0 are dropped here, once for the whole pipeline
    assign dec.reg_we = (is_op || is_op_imm || is_lui) && funct_ok && (rd != '0);

endmodule

`default_nettype wire

//--- reg_file.sv
`default_nettype none

module reg_file (
    input  wire logic              clk,
    input  wire rv_pkg::reg_addr_t rs1_addr,
    input  wire rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::word_t          rs1_data,
    output rv_pkg::word_t          rs2_data,
    input  wire logic              wb_we,
    input  wire rv_pkg::reg_addr_t wb_rd,
    input  wire rv_pkg::word_t     wb_data
);

    rv_pkg::word_t regs [32];

    // Write port, wb_we never comes with x0 as the target
    always_ff @(posedge clk) begin
        if (wb_we) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Asynchronous read ports
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rv_core -f files.f -o sim_rv_core

sim_out=$(./obj_dir/sim_rv_core || true)
echo "$sim_out"

if grep -qx "TB PASSED" <<< "$sim_out"; then
    exit 0
fi
exit 1

//--- rv_core.sv
`default_nettype none

module rv_core (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic [31:0] inst,
    input  wire logic        inst_valid,
    output logic             inst_ready,
    output logic             retire_valid,
    input  wire logic        retire_ready,
    output logic [4:0]       retire_rd,
    output logic             retire_we,
    output logic [31:0]      retire_data
);

    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;
    logic              wb_we;
    rv_pkg::reg_addr_t wb_rd;
    rv_pkg::word_t     wb_data;

    dec_if dec_bus ();

    inst_decode decode_i (
        .inst (inst),
        .dec  (dec_bus)
    );

    // Register read runs alongside decode
    reg_file reg_file_i (
        .clk      (clk),
        .rs1_addr (dec_bus.rs1_addr),
        .rs2_addr (dec_bus.rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_we    (wb_we),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    execute_stage execute_i (
        .clk          (clk),
        .rst          (rst),
        .inst_valid   (inst_valid),
        .inst_ready   (inst_ready),
        .dec          (dec_bus),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .wb_we        (wb_we),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_rd    (retire_rd),
        .retire_we    (retire_we),
        .retire_data  (retire_data)
    );

endmodule

`default_nettype wire

//--- rv_core_assertions.sv
`default_nettype none

module rv_core_assertions (
    input wire logic        clk,
    input wire logic        rst,
    input wire logic        retire_valid,
    input wire logic        retire_ready,
    input wire logic [4:0]  retire_rd,
    input wire logic        retire_we,
    input wire logic [31:0] retire_data
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;  // Read by the testbench at the end of the run

    // R comes out of reset empty
    reset_empty: assert property (@(posedge clk) rst |=> !retire_valid)
        else begin
            $error("retire_valid high in the cycle after reset");
            fail_count++;
        end

    // A stalled retire keeps all of its outputs
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        (retire_valid && !retire_ready) |=>
            (retire_valid && $stable(retire_rd) && $stable(retire_we) && $stable(retire_data)))
        else begin
            $error("retire outputs changed while stalled");
            fail_count++;
        end

    we_not_x0: assert property (@(posedge clk) disable iff (rst)
        (retire_valid && retire_we) |-> (retire_rd != 5'd0))
        else begin
            $error("retire_we high with retire_rd of x0");
            fail_count++;
        end

endmodule

bind execute_stage rv_core_assertions assert_i (
    .clk          (clk),
    .rst          (rst),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire_rd    (retire_rd),
    .retire_we    (retire_we),
    .retire_data  (retire_data)
);

`default_nettype wire

//--- rv_core_stimulus.txt
# test inst rd we result, all hex; test 5 replays tests 1 to 4 under back-pressure
# result is only compared when we is 1
1 06400093 01 1 00000064
1 ff900113 02 1 fffffff9
1 5a506193 03 1 000005a5
1 123452b7 05 1 12345000
1 0ff1f213 04 1 000000a5
1 fff0c313 06 1 ffffff9b
1 ffa12393 07 1 00000001
1 0320a413 08 1 00000000
2 002084b3 09 1 0000005d
2 40208533 0a 1 0000006b
2 0061f5b3 0b 1 00000581
2 0032e633 0c 1 123455a5
2 003346b3 0d 1 fffffa3e
2 00112733 0e 1 00000001
2 0020a7b3 0f 1 00000000
2 00119833 10 1 00005a50
2 0012d8b3 11 1 01234500
2 00915933 12 1 00000007
3 00300993 13 1 00000003
3 013989b3 13 1 00000006
3 00499a13 14 1 00000060
3 401a0a33 14 1 fffffffc
3 01ca5a93 15 1 0000000f
3 014acab3 15 1 fffffff3
3 013aab33 16 1 00000001
4 00508013 00 0 00000000
4 00100bb3 17 1 00000064
4 0020bc33 18 0 00000000
4 40115db3 1b 0 00000000
4 00001c97 19 0 00000000
4 00006d33 1a 1 00000000

//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;      // Register or data value
    typedef logic [4:0]  reg_addr_t;  // Register index
    typedef logic [3:0]  alu_op_t;

    // ALU operation codes
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLT    = 4'd5;  // Signed compare
    localparam alu_op_t ALU_SLL    = 4'd6;
    localparam alu_op_t ALU_SRL    = 4'd7;
    localparam alu_op_t ALU_PASS_B = 4'd8;  // Result is operand B, for LUI

    // Major opcodes, inst[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

endpackage

`default_nettype wire

//--- tb_rv_core.sv
`default_nettype none

module tb_rv_core;

    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rst;
    logic [31:0] inst;
    logic        inst_valid;
    logic        inst_ready;
    logic        retire_valid;
    logic        retire_ready;
    logic [4:0]  retire_rd;
    logic        retire_we;
    logic [31:0] retire_data;

    // One entry per stimulus line
    int          test_q[$];
    logic [31:0] inst_q[$];
    logic [4:0]  rd_q[$];
    logic        we_q[$];
    logic [31:0] data_q[$];

    int n_vec;
    int total;       // Program runs twice, second time under back-pressure
    int limit;
    int cycles;
    int checks;
    int errors;
    int sent;        // Instructions accepted so far
    bit timed_out;
    int test_count[6];
    int test_errors[6];

    rv_core dut_i (
        .clk          (clk),
        .rst          (rst),
        .inst         (inst),
        .inst_valid   (inst_valid),
        .inst_ready   (inst_ready),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_rd    (retire_rd),
        .retire_we    (retire_we),
        .retire_data  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int test_of(int k);
        return (k < n_vec) ? test_q[k] : 5;
    endfunction

    function automatic string test_name(int t);
        case (t)
            1: return "immediates and LUI";
            2: return "register-register";
            3: return "back-to-back dependencies";
            4: return "x0 writes and unsupported opcodes";
            default: return "back-pressure replay";
        endcase
    endfunction

    task automatic load_stimulus();
        int          fd;
        int          fields;
        string       line;
        int          t;
        logic [31:0] word;
        logic [31:0] rd_v;
        logic [31:0] we_v;
        logic [31:0] data;
        fd = $fopen("rv_core_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open rv_core_stimulus.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line[0] != "#") begin   // Skip column notes
                fields = $sscanf(line, "%h %h %h %h %h", t, word, rd_v, we_v, data);
                if (fields == 5) begin
                    test_q.push_back(t);
                    inst_q.push_back(word);
                    rd_q.push_back(rd_v[4:0]);
                    we_q.push_back(we_v[0]);
                    data_q.push_back(data);
                end
            end
        end
        $fclose(fd);
    endtask

    // Keeps inst_valid high and advances only after a transfer
    task automatic drive_program();
        bit fire;
        @(posedge clk);
        inst       <= inst_q[0];
        inst_valid <= 1'b1;
        while (sent < total) begin
            @(negedge clk);
            fire = inst_valid && inst_ready;
            @(posedge clk);
            if (fire) begin
                sent++;
                if (sent < total) begin
                    inst <= inst_q[sent % n_vec];
                end else begin
                    inst_valid <= 1'b0;
                end
            end
        end
    endtask

    task automatic compare_retire(int k);
        int idx;
        int t;
        int bad;
        idx = k % n_vec;
        t   = test_of(k);
        bad = 0;
        if (retire_rd !== rd_q[idx]) begin
            $display("ERROR %0t retire_rd expected %0d actual %0d", $time, rd_q[idx], retire_rd);
            bad++;
        end
        if (retire_we !== we_q[idx]) begin
            $display("ERROR %0t retire_we expected %0b actual %0b", $time, we_q[idx], retire_we);
            bad++;
        end
        if (we_q[idx] && retire_data !== data_q[idx]) begin
            $display("ERROR %0t retire_data expected %h actual %h",
                     $time, data_q[idx], retire_data);
            bad++;
        end
        checks++;
        test_count[t]++;
        test_errors[t] += bad;
        errors += bad;
        if (k + 1 == total || test_of(k + 1) != t) begin
            $display("test %0d (%s): %0d retires, %0d errors",
                     t, test_name(t), test_count[t], test_errors[t]);
        end
    endtask

    // Samples at the falling edge, drives retire_ready at the rising edge
    task automatic check_retires();
        int          retired;
        bit          held;
        logic [4:0]  held_rd;
        logic        held_we;
        logic [31:0] held_data;
        logic        exp_ready;
        retired = 0;
        held    = 1'b0;
        while (retired < total && cycles < limit) begin
            @(negedge clk);
            cycles++;
            // Two in flight means S1 and R are full, so a stalled R blocks intake
            exp_ready = !(((sent - retired) == 2) && !retire_ready);
            if (inst_ready !== exp_ready) begin
                $display("ERROR %0t inst_ready expected %0b actual %0b",
                         $time, exp_ready, inst_ready);
                errors++;
            end
            if (held && !retire_valid) begin
                $display("retire_valid dropped while the retire was stalled");
                errors++;
            end
            if (held && retire_rd !== held_rd) begin
                $display("ERROR %0t retire_rd expected %0d actual %0d",
                         $time, held_rd, retire_rd);
                errors++;
            end
            if (held && retire_we !== held_we) begin
                $display("ERROR %0t retire_we expected %0b actual %0b",
                         $time, held_we, retire_we);
                errors++;
            end
            if (held && retire_data !== held_data) begin
                $display("ERROR %0t retire_data expected %h actual %h",
                         $time, held_data, retire_data);
                errors++;
            end
            held      = retire_valid && !retire_ready;
            held_rd   = retire_rd;
            held_we   = retire_we;
            held_data = retire_data;
            if (retire_valid && retire_ready) begin
                compare_retire(retired);
                retired++;
            end
            @(posedge clk);
            if (retired >= n_vec) begin
                retire_ready <= (($urandom % 3) != 0);
            end else begin
                retire_ready <= 1'b1;
            end
        end
        if (retired < total) begin
            $display("Timeout after %0d cycles, %0d of %0d retires never arrived",
                     cycles, total - retired, total);
            timed_out = 1'b1;
            errors++;
        end
    endtask

    // Nothing may retire once the program is done
    task automatic check_idle();
        repeat (5) begin
            @(negedge clk);
            if (retire_valid) begin
                $display("Extra retire seen after the last instruction, rd %0d", retire_rd);
                errors++;
            end
        end
    endtask

    initial begin
        rst          = 1'b1;
        inst         = '0;
        inst_valid   = 1'b0;
        retire_ready = 1'b0;
        cycles       = 0;
        checks       = 0;
        errors       = 0;
        sent         = 0;
        timed_out    = 1'b0;
        void'($urandom(74552));
        load_stimulus();
        n_vec = inst_q.size();
        total = 2 * n_vec;
        limit = 8 * n_vec + 100;
        repeat (10) @(posedge clk);
        rst          <= 1'b0;
        retire_ready <= 1'b1;
        if (n_vec == 0) begin
            $display("No instructions were loaded from the stimulus file");
            errors++;
        end else begin
            fork
                drive_program();
            join_none
            check_retires();
            if (!timed_out) begin
                check_idle();
            end
        end
        if (dut_i.execute_i.assert_i.fail_count != 0) begin
            $display("%0d assertion failures", dut_i.execute_i.assert_i.fail_count);
            errors += dut_i.execute_i.assert_i.fail_count;
        end
        $display("%0d retires checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
